// File: logic/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// byte address and data word widths
`define CACHE_ADDR_W     32
`define CACHE_WORD_W     32

// array geometry
`define CACHE_LINE_WORDS 4
`define CACHE_SETS       2
`define CACHE_WAYS       2

// tag sits above the set index, which sits above the line offset
`define CACHE_TAG_W      27
`define CACHE_OFFSET_W   4      // word select plus byte offset

`endif

// File: logic/cache_pkg.sv
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

        typedef logic [`CACHE_ADDR_W-1:0] addr_t;
        typedef logic [`CACHE_WORD_W-1:0] word_t;
        typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_W-1:0] line_t;  // word 0 in the low bits
        typedef logic [`CACHE_TAG_W-1:0] tag_t;
        typedef logic [$clog2(`CACHE_SETS)-1:0] set_t;
        typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

        // one tag array entry
        typedef struct packed {
                logic valid;
                logic dirty;
                tag_t tag;
        } tag_entry_t;

        typedef enum logic [2:0] {
                IDLE       = 3'd0,
                LOOKUP     = 3'd1,
                EVICT      = 3'd2,      // write-back request goes out
                EVICT_WAIT = 3'd3,
                FILL       = 3'd4,      // line read request goes out
                FILL_WAIT  = 3'd5
        } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/cache_ifs.sv
`default_nettype none

`include "cache_consts.svh"

//////////////////////////////////////////////////////////////////////
// controller <-> tag store
//////////////////////////////////////////////////////////////////////
interface tag_if;
        import cache_pkg::*;

        set_t lookup_set;
        tag_t lookup_tag;
        logic touch;            // make touch_way most recently used
        way_t touch_way;
        logic fill;             // install lookup_tag into fill_way
        way_t fill_way;
        logic set_dirty;        // mark hit_way dirty

        logic hit;
        way_t hit_way;
        way_t victim_way;
        logic victim_dirty;
        tag_t victim_tag;

        modport ctrl (output lookup_set, lookup_tag, touch, touch_way, fill, fill_way,
                      set_dirty, input hit, hit_way, victim_way, victim_dirty, victim_tag);
        modport store (input lookup_set, lookup_tag, touch, touch_way, fill, fill_way,
                       set_dirty, output hit, hit_way, victim_way, victim_dirty, victim_tag);
endinterface

//////////////////////////////////////////////////////////////////////
// controller and request latch <-> data store
//////////////////////////////////////////////////////////////////////
interface data_if;
        import cache_pkg::*;

        set_t set;
        way_t way;
        logic [$clog2(`CACHE_LINE_WORDS)-1:0] word_sel;         // from the request latch
        logic [$clog2(`CACHE_WORD_W/8)-1:0] byte_sel;
        logic byte_mode;
        logic word_wr;
        word_t wdata;
        logic line_wr;
        line_t fill_line;

        word_t rd_word;
        line_t rd_line;

        // word_sel, byte_sel, byte_mode and wdata are driven by the request latch
        modport ctrl (output set, way, word_wr, line_wr, fill_line);
        modport store (input set, way, word_sel, byte_sel, byte_mode, word_wr, wdata,
                       line_wr, fill_line, output rd_word, rd_line);
endinterface

`default_nettype wire

// File: logic/way_array.sv
`default_nettype none

`include "cache_consts.svh"

// sets x ways of one payload, every way of a set readable at once
module way_array
        #(
        parameter type payload_t = logic,
        parameter payload_t reset_val = '0
        )
        (
        input  logic             clk,
        input  logic             reset,
        input  cache_pkg::set_t  rd_set,
        output payload_t         rd_data [`CACHE_WAYS],
        input  logic             wr_en,
        input  cache_pkg::set_t  wr_set,
        input  cache_pkg::way_t  wr_way,
        input  payload_t         wr_data
        );

        payload_t entry [`CACHE_SETS][`CACHE_WAYS];

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        for (int s = 0; s < `CACHE_SETS; s++)
                        begin
                                for (int w = 0; w < `CACHE_WAYS; w++)
                                begin
                                        entry[s][w] <= reset_val;
                                end
                        end
                end
                else if (wr_en)
                begin
                        entry[wr_set][wr_way] <= wr_data;   // one entry per cycle
                end
        end

        assign rd_data = entry[rd_set];

endmodule

`default_nettype wire

// File: logic/tag_store.sv
`default_nettype none

`include "cache_consts.svh"

module tag_store
        (
        input logic     clk,
        input logic     reset,
        tag_if.store    tags
        );

        import cache_pkg::*;

        tag_entry_t entry [`CACHE_WAYS];        // both ways of the lookup set
        tag_entry_t wr_entry;
        way_t wr_way;
        logic [`CACHE_SETS-1:0] lru;            // per set, the way to replace next

        way_array #(
                .payload_t(tag_entry_t),
                .reset_val('0)
        ) tag_array_inst (
                .clk(clk),
                .reset(reset),
                .rd_set(tags.lookup_set),
                .rd_data(entry),
                .wr_en(tags.fill || tags.set_dirty),
                .wr_set(tags.lookup_set),
                .wr_way(wr_way),
                .wr_data(wr_entry)
        );

        //////////////////////////////////////////////////////////////////////
        // lookup
        //////////////////////////////////////////////////////////////////////
        always_comb
        begin
                tags.hit = 1'b0;
                tags.hit_way = '0;
                for (int w = 0; w < `CACHE_WAYS; w++)
                begin
                        if (entry[w].valid && entry[w].tag == tags.lookup_tag)
                        begin
                                tags.hit = 1'b1;
                                tags.hit_way = way_t'(w);
                        end
                end
        end

        assign tags.victim_way = lru[tags.lookup_set];
        assign tags.victim_dirty = entry[tags.victim_way].dirty;
        assign tags.victim_tag = entry[tags.victim_way].tag;

        //////////////////////////////////////////////////////////////////////
        // update
        //////////////////////////////////////////////////////////////////////
        always_comb
        begin
                if (tags.fill)
                begin
                        wr_way = tags.fill_way;
                        wr_entry = '{valid: 1'b1, dirty: 1'b0, tag: tags.lookup_tag};
                end
                else
                begin
                        // write hit, keep the tag and set dirty
                        wr_way = tags.hit_way;
                        wr_entry = entry[tags.hit_way];
                        wr_entry.dirty = 1'b1;
                end
        end

        // two ways, so the other way becomes lru
        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        lru <= '0;
                end
                else if (tags.touch)
                begin
                        lru[tags.lookup_set] <= ~tags.touch_way;
                end
                else if (tags.fill)
                begin
                        lru[tags.lookup_set] <= ~tags.fill_way;
                end
        end

endmodule

`default_nettype wire

// File: logic/data_store.sv
`default_nettype none

`include "cache_consts.svh"

module data_store
        (
        input logic     clk,
        input logic     reset,
        data_if.store   data
        );

        import cache_pkg::*;

        line_t lines [`CACHE_WAYS];
        line_t cur_line;                // line of the chosen way
        line_t merged;                  // cur_line with the store word in place
        word_t cur_word;

        way_array #(
                .payload_t(line_t),
                .reset_val('0)
        ) line_array_inst (
                .clk(clk),
                .reset(reset),
                .rd_set(data.set),
                .rd_data(lines),
                .wr_en(data.word_wr || data.line_wr),
                .wr_set(data.set),
                .wr_way(data.way),
                .wr_data(data.line_wr ? data.fill_line : merged)
        );

        //////////////////////////////////////////////////////////////////////
        // read side
        //////////////////////////////////////////////////////////////////////
        assign cur_line = lines[data.way];
        assign cur_word = cur_line[data.word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

        assign data.rd_line = cur_line;         // also the write-back data

        // byte mode returns the addressed byte, zero extended
        assign data.rd_word = data.byte_mode ? word_t'(cur_word[data.byte_sel*8 +: 8])
                                             : cur_word;

        //////////////////////////////////////////////////////////////////////
        // write side
        //////////////////////////////////////////////////////////////////////
        always_comb
        begin
                merged = cur_line;
                merged[data.word_sel*`CACHE_WORD_W +: `CACHE_WORD_W] = data.wdata;
        end

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl
        (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    req_read,
        input  logic                    req_write,
        input  cache_pkg::set_t         req_set,
        input  cache_pkg::tag_t         req_tag,
        output logic                    stall_pc,
        output logic                    cpu_rvalid,
        output logic                    mem_req,
        output logic                    mem_we,
        output cache_pkg::addr_t        mem_addr,
        input  logic                    mem_ack,
        input  cache_pkg::line_t        mem_rdata,
        tag_if.ctrl                     tags,
        data_if.ctrl                    data
        );

        import cache_pkg::*;

        ctrl_state_t state;
        ctrl_state_t state_next;
        logic lookup_hit;       // request completes this cycle
        logic fill_done;        // line arrives from memory

        assign lookup_hit = (state == LOOKUP) && tags.hit;
        assign fill_done = (state == FILL_WAIT) && mem_ack;

        //////////////////////////////////////////////////////////////////////
        // state machine
        //////////////////////////////////////////////////////////////////////
        always_comb
        begin
                state_next = state;
                case (state)
                IDLE:
                begin
                        if (req_read || req_write)
                        begin
                                state_next = LOOKUP;
                        end
                end
                LOOKUP:
                begin
                        if (tags.hit)
                        begin
                                state_next = IDLE;
                        end
                        else if (tags.victim_dirty)
                        begin
                                state_next = EVICT;
                        end
                        else
                        begin
                                state_next = FILL;
                        end
                end
                EVICT:
                begin
                        state_next = EVICT_WAIT;
                end
                EVICT_WAIT:
                begin
                        if (mem_ack)
                        begin
                                state_next = FILL;
                        end
                end
                FILL:
                begin
                        state_next = FILL_WAIT;
                end
                FILL_WAIT:
                begin
                        if (mem_ack)
                        begin
                                state_next = LOOKUP;    // looks up again and hits
                        end
                end
                default:
                begin
                        state_next = IDLE;
                end
                endcase
        end

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        state <= IDLE;
                        cpu_rvalid <= 1'b0;
                end
                else
                begin
                        state <= state_next;
                        cpu_rvalid <= lookup_hit && req_read;
                end
        end

        assign stall_pc = (state != IDLE);      // strobes are ignored while set

        //////////////////////////////////////////////////////////////////////
        // store controls
        //////////////////////////////////////////////////////////////////////
        assign tags.lookup_set = req_set;
        assign tags.lookup_tag = req_tag;
        assign tags.touch = lookup_hit;
        assign tags.touch_way = tags.hit_way;
        assign tags.set_dirty = lookup_hit && req_write;
        assign tags.fill = fill_done;
        assign tags.fill_way = tags.victim_way;

        // the victim way is read for write-back and written on fill
        assign data.set = req_set;
        assign data.way = tags.hit ? tags.hit_way : tags.victim_way;
        assign data.word_wr = lookup_hit && req_write;
        assign data.line_wr = fill_done;
        assign data.fill_line = mem_rdata;

        // memory strobes, one cycle each in EVICT and FILL
        assign mem_req = (state == EVICT) || (state == FILL);
        assign mem_we = (state == EVICT);
        assign mem_addr = mem_we ? {tags.victim_tag, req_set, {`CACHE_OFFSET_W{1'b0}}}
                                 : {req_tag, req_set, {`CACHE_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

// File: logic/cache_top.sv
`default_nettype none

`include "cache_consts.svh"

module cache_top
        (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    cpu_read,
        input  logic                    cpu_write,
        input  logic                    cpu_byte,
        input  cache_pkg::addr_t        cpu_addr,
        input  cache_pkg::word_t        cpu_wdata,
        output cache_pkg::word_t        cpu_rdata,
        output logic                    cpu_rvalid,
        output logic                    stall_pc,
        output logic                    mem_req,
        output logic                    mem_we,
        output cache_pkg::addr_t        mem_addr,
        output cache_pkg::line_t        mem_wdata,
        input  logic                    mem_ack,
        input  cache_pkg::line_t        mem_rdata
        );

        import cache_pkg::*;

        logic start;            // request sampled at this edge
        logic read_q;
        logic write_q;
        logic byte_q;
        addr_t addr_q;
        word_t wdata_q;

        tag_if tif ();
        data_if dif ();

        //////////////////////////////////////////////////////////////////////
        // request latch
        //////////////////////////////////////////////////////////////////////
        assign start = (cpu_read || cpu_write) && !stall_pc;

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        read_q <= 1'b0;
                        write_q <= 1'b0;
                end
                else if (start)
                begin
                        read_q <= cpu_read;
                        write_q <= cpu_write;
                end
        end

        always_ff @(posedge clk)
        begin
                if (start)
                begin
                        addr_q <= cpu_addr;
                        wdata_q <= cpu_wdata;
                        byte_q <= cpu_byte;
                end
        end

        assign dif.word_sel = addr_q[`CACHE_OFFSET_W-1:2];
        assign dif.byte_sel = addr_q[1:0];
        assign dif.byte_mode = byte_q;
        assign dif.wdata = wdata_q;

        assign cpu_rdata = dif.rd_word;         // valid with cpu_rvalid
        assign mem_wdata = dif.rd_line;         // victim line during EVICT

        //////////////////////////////////////////////////////////////////////
        // blocks
        //////////////////////////////////////////////////////////////////////
        cache_ctrl ctrl_inst (
                .clk(clk),
                .reset(reset),
                .req_read(stall_pc ? read_q : cpu_read),        // raw strobe while idle
                .req_write(stall_pc ? write_q : cpu_write),
                .req_set(addr_q[`CACHE_OFFSET_W]),
                .req_tag(addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W]),
                .stall_pc(stall_pc),
                .cpu_rvalid(cpu_rvalid),
                .mem_req(mem_req),
                .mem_we(mem_we),
                .mem_addr(mem_addr),
                .mem_ack(mem_ack),
                .mem_rdata(mem_rdata),
                .tags(tif.ctrl),
                .data(dif.ctrl)
        );

        tag_store tag_store_inst (
                .clk(clk),
                .reset(reset),
                .tags(tif.store)
        );

        data_store data_store_inst (
                .clk(clk),
                .reset(reset),
                .data(dif.store)
        );

endmodule

`default_nettype wire

// File: test/cache_chk.sv
`default_nettype none

// handshake rules bound into the cache controller
module cache_chk
        (
        input logic     clk,
        input logic     reset,
        input logic     stall_pc,
        input logic     cpu_rvalid,
        input logic     mem_req,
        input logic     mem_ack
        );

        timeunit 1ns;
        timeprecision 100ps;

        logic outstanding;      // memory request sent and not yet acked
        logic failed = 1'b0;    // raised by any failing assertion

        always_ff @(posedge clk or posedge reset)
        begin
                if (reset)
                begin
                        outstanding <= 1'b0;
                end
                else if (mem_ack)
                begin
                        outstanding <= 1'b0;
                end
                else if (mem_req)
                begin
                        outstanding <= 1'b1;
                end
        end

        mem_req_one_cycle: assert property (@(posedge clk) disable iff (reset)
                mem_req |=> !mem_req)
                else
                begin
                        $error("mem_req held for more than one cycle");
                        failed = 1'b1;
                end

        mem_req_single_outstanding: assert property (@(posedge clk) disable iff (reset)
                mem_req |-> !outstanding)
                else
                begin
                        $error("mem_req issued before mem_ack of the previous request");
                        failed = 1'b1;
                end

        rvalid_with_stall_fall: assert property (@(posedge clk) disable iff (reset)
                cpu_rvalid |-> $fell(stall_pc))
                else
                begin
                        $error("cpu_rvalid without stall_pc falling");
                        failed = 1'b1;
                end

endmodule

`default_nettype wire

// File: test/cache_tb.sv
`default_nettype none

`include "cache_consts.svh"

module cache_tb;

        timeunit 1ns;
        timeprecision 100ps;

        import cache_pkg::*;

        localparam int num_requests = 400;
        localparam int timeout_cycles = num_requests * 30 + 8;

        logic clk = 1'b0;
        logic reset;
        logic cpu_read;
        logic cpu_write;
        logic cpu_byte;
        addr_t cpu_addr;
        word_t cpu_wdata;
        word_t cpu_rdata;
        logic cpu_rvalid;
        logic stall_pc;
        logic mem_req;
        logic mem_we;
        addr_t mem_addr;
        line_t mem_wdata;
        logic mem_ack;
        line_t mem_rdata;

        word_t shadow_mem [addr_t];     // what the cpu should see
        word_t main_mem [addr_t];       // sparse main memory
        logic valid_m [`CACHE_SETS][`CACHE_WAYS];
        logic dirty_m [`CACHE_SETS][`CACHE_WAYS];
        tag_t tag_m [`CACHE_SETS][`CACHE_WAYS];
        way_t lru_m [`CACHE_SETS];
        tag_t tag_pool [4] = '{27'h0000001, 27'h0012345, 27'h2aaaaaa, 27'h7fffffe};
        integer seed;
        int req_num = 0;
        int cycle_count = 0;

        cache_top cache_top_inst (
                .clk(clk),
                .reset(reset),
                .cpu_read(cpu_read),
                .cpu_write(cpu_write),
                .cpu_byte(cpu_byte),
                .cpu_addr(cpu_addr),
                .cpu_wdata(cpu_wdata),
                .cpu_rdata(cpu_rdata),
                .cpu_rvalid(cpu_rvalid),
                .stall_pc(stall_pc),
                .mem_req(mem_req),
                .mem_we(mem_we),
                .mem_addr(mem_addr),
                .mem_wdata(mem_wdata),
                .mem_ack(mem_ack),
                .mem_rdata(mem_rdata)
        );

        bind cache_ctrl cache_chk cache_chk_inst (
                .clk(clk),
                .reset(reset),
                .stall_pc(stall_pc),
                .cpu_rvalid(cpu_rvalid),
                .mem_req(mem_req),
                .mem_ack(mem_ack)
        );

        always #2 clk = ~clk;

        always @(posedge clk)
        begin
                cycle_count <= cycle_count + 1;
                if (cycle_count > timeout_cycles)
                begin
                        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
                        $display("TEST FAIL");
                        $fatal(1);
                end
        end

        always @(posedge cache_top_inst.ctrl_inst.cache_chk_inst.failed)
        begin
                $display("a handshake assertion in the cache controller failed");
                $display("TEST FAIL");
                $fatal(1);
        end

        //////////////////////////////////////////////////////////////////////
        // helpers
        //////////////////////////////////////////////////////////////////////
        task automatic compare_value(input string name, input logic [127:0] expected,
                                     input logic [127:0] actual);
                if (expected !== actual)
                begin
                        $display("FAIL %s (request %0d): expected %h, actual %h",
                                 name, req_num, expected, actual);
                        $display("TEST FAIL");
                        $fatal(1);
                end
        endtask

        // unwritten words read as their own address inverted
        function automatic word_t fetch_word(input logic from_shadow, input addr_t a);
                if (from_shadow)
                begin
                        return shadow_mem.exists(a) ? shadow_mem[a] : ~a;
                end
                return main_mem.exists(a) ? main_mem[a] : ~a;
        endfunction

        function automatic line_t fetch_line(input logic from_shadow, input addr_t a);
                line_t l;
                for (int i = 0; i < `CACHE_LINE_WORDS; i++)
                begin
                        l[i*`CACHE_WORD_W +: `CACHE_WORD_W] = fetch_word(from_shadow, a + 4 * i);
                end
                return l;
        endfunction

        //////////////////////////////////////////////////////////////////////
        // one cpu request with the memory side answered inline
        //////////////////////////////////////////////////////////////////////
        task automatic run_request(input logic is_write, input logic is_byte,
                                   input addr_t addr, input word_t wdata);
                set_t s;
                tag_t t;
                way_t w;
                logic hit;
                logic exp_wb;
                addr_t line_addr;
                addr_t wb_addr;
                word_t exp_rd;
                line_t pend_line;
                int edges;
                int n_req;
                int ack_cnt;
                logic done;

                s = addr[`CACHE_OFFSET_W];
                t = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
                line_addr = {t, s, {`CACHE_OFFSET_W{1'b0}}};
                hit = 1'b0;
                w = lru_m[s];
                for (int i = 0; i < `CACHE_WAYS; i++)
                begin
                        if (valid_m[s][i] && tag_m[s][i] == t)
                        begin
                                hit = 1'b1;
                                w = way_t'(i);
                        end
                end
                exp_wb = !hit && valid_m[s][w] && dirty_m[s][w];
                wb_addr = {tag_m[s][w], s, {`CACHE_OFFSET_W{1'b0}}};
                pend_line = '0;

                @(posedge clk);
                cpu_read <= !is_write;
                cpu_write <= is_write;
                cpu_byte <= is_byte;
                cpu_addr <= addr;
                cpu_wdata <= wdata;

                edges = 0;
                n_req = 0;
                ack_cnt = 0;
                done = 1'b0;
                while (!done)
                begin
                        @(posedge clk);         // first pass is the sampling edge
                        cpu_read <= 1'b0;
                        cpu_write <= 1'b0;
                        mem_ack <= 1'b0;
                        if (ack_cnt > 0)
                        begin
                                ack_cnt--;
                                if (ack_cnt == 0)
                                begin
                                        mem_ack <= 1'b1;
                                        mem_rdata <= pend_line;
                                end
                        end
                        @(negedge clk);
                        edges++;
                        if (mem_req)
                        begin
                                n_req++;
                                if (n_req == 1 && exp_wb)
                                begin
                                        compare_value("writeback_we", 1'b1, mem_we);
                                        compare_value("writeback_addr", wb_addr, mem_addr);
                                        compare_value("writeback_data", fetch_line(1'b1, wb_addr),
                                                      mem_wdata);
                                        for (int i = 0; i < `CACHE_LINE_WORDS; i++)
                                        begin
                                                main_mem[mem_addr + 4 * i] =
                                                        mem_wdata[i*`CACHE_WORD_W +: `CACHE_WORD_W];
                                        end
                                end
                                else
                                begin
                                        compare_value("fill_we", 1'b0, mem_we);
                                        compare_value("fill_addr", line_addr, mem_addr);
                                        pend_line = fetch_line(1'b0, mem_addr);
                                end
                                ack_cnt = 1 + $unsigned($random(seed)) % 8;
                        end
                        if (stall_pc)
                        begin
                                compare_value("rvalid_while_stalled", 1'b0, cpu_rvalid);
                        end
                        else
                        begin
                                done = 1'b1;
                        end
                end

                compare_value("memory_requests", hit ? 0 : (exp_wb ? 2 : 1), n_req);
                if (hit)
                begin
                        compare_value("hit_latency", 2, edges);
                end
                compare_value("rvalid_at_done", !is_write, cpu_rvalid);
                if (!is_write)
                begin
                        exp_rd = fetch_word(1'b1, {addr[`CACHE_ADDR_W-1:2], 2'b00});
                        if (is_byte)
                        begin
                                exp_rd = (exp_rd >> (8 * addr[1:0])) & 32'hff;
                        end
                        compare_value("read_data", exp_rd, cpu_rdata);
                end

                // the filled or hit way becomes mru in the reference
                if (!hit)
                begin
                        tag_m[s][w] = t;
                        valid_m[s][w] = 1'b1;
                        dirty_m[s][w] = 1'b0;
                end
                lru_m[s] = ~w;
                if (is_write)
                begin
                        dirty_m[s][w] = 1'b1;
                        shadow_mem[{addr[`CACHE_ADDR_W-1:2], 2'b00}] = wdata;
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // main sequence
        //////////////////////////////////////////////////////////////////////
        initial
        begin
                logic [31:0] r;
                addr_t addr;
                word_t wdata;

                seed = 32'h80481325;
                reset = 1'b1;
                cpu_read = 1'b0;
                cpu_write = 1'b0;
                cpu_byte = 1'b0;
                cpu_addr = '0;
                cpu_wdata = '0;
                mem_ack = 1'b0;
                mem_rdata = '0;
                for (int s = 0; s < `CACHE_SETS; s++)
                begin
                        lru_m[s] = '0;
                        for (int w = 0; w < `CACHE_WAYS; w++)
                        begin
                                valid_m[s][w] = 1'b0;
                                dirty_m[s][w] = 1'b0;
                                tag_m[s][w] = '0;
                        end
                end

                repeat (8) @(posedge clk);
                reset <= 1'b0;
                @(negedge clk);
                compare_value("reset_stall_pc", 1'b0, stall_pc);
                compare_value("reset_cpu_rvalid", 1'b0, cpu_rvalid);
                compare_value("reset_mem_req", 1'b0, mem_req);

                // few tags per set so lines conflict and get evicted often
                for (req_num = 1; req_num <= num_requests; req_num++)
                begin
                        r = $random(seed);
                        addr = {tag_pool[r[3:2]], r[4], r[6:5], r[8:7]};
                        wdata = $random(seed);
                        run_request(r[0], r[1] & ~r[0], addr, wdata);
                end

                // let the handshake assertions see the last request complete
                repeat (2) @(posedge clk);

                $display("TEST PASS");
                $finish;
        end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_ifs.sv
logic/way_array.sv
logic/tag_store.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
test/cache_chk.sv
test/cache_tb.sv
